/* design/exeStage_defines.svh */
`ifndef EXE_STAGE_DEFINES_SVH
`define EXE_STAGE_DEFINES_SVH

// datapath and register file
`define DATA_W      32
`define REG_ADDR_W  5

// jal/jalr write back pc plus this
`define LINK_OFFSET 8

// multi-cycle unit latency, counted from the start cycle
`define DIV_STEPS   32
`define MULT_STEPS  2

`endif

/* design/exePkg.sv */
`include "exeStage_defines.svh"

package exePkg;

    typedef enum logic [4:0] {
        opAdd,
        opAddu,
        opSub,
        opSubu,
        opAnd,
        opOr,
        opXor,
        opNor,
        opSlt,
        opSltu,
        opSll,
        opSrl,
        opSra,
        opLui,
        opMult,
        opMultu,
        opDiv,
        opDivu,
        opMthi,
        opMtlo,
        opNop
    } aluOpE;

    typedef enum logic [2:0] {
        brNone,
        brBeq,
        brBne,
        brBgez,
        brBgtz,
        brBlez,
        brBltz,
        brJr
    } branchTypeE;

    typedef struct packed {
        logic gprWr;
        logic hiWr;
        logic loWr;
    } regsWrT;

    typedef enum logic [1:0] {wbLink, wbAluOut, wbOutB} wbSelE;
    typedef enum logic [1:0] {dstRd, dstRt, dstRa} dstSelE;
    typedef enum logic [1:0] {readBusB, readHi, readLo} readSelE;

    typedef struct packed {
        logic overflow;
        logic reserved;
        logic syscall;
        logic breakPt;
    } exceptT;

    // decoded instruction entering execute
    typedef struct packed {
        logic [`DATA_W-1:0]     busA;
        logic [`DATA_W-1:0]     busB;
        logic [`DATA_W-1:0]     imm32;
        logic [`DATA_W-1:0]     pc;
        logic [`DATA_W-1:0]     instr;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        aluOpE                  aluOp;
        regsWrT                 regsWr;
        wbSelE                  wbSel;
        dstSelE                 dstSel;
        readSelE                readSel;
        logic                   aluSrcA;  // 1: shamt
        logic                   aluSrcB;  // 1: imm32
        branchTypeE             branchType;
        exceptT                 except;
    } idExeT;

    typedef struct packed {
        logic [`DATA_W-1:0]     pc;
        logic [`DATA_W-1:0]     aluOut;
        logic [`DATA_W-1:0]     outB;
        logic [`DATA_W-1:0]     result;  // bypass value
        logic [`REG_ADDR_W-1:0] dst;
        regsWrT                 regsWr;
        wbSelE                  wbSel;
        exceptT                 except;
    } exeMemT;

endpackage

/* design/exeReg.sv */
`timescale 1ns/1ps

module exeReg (
    input  logic          clk,
    input  logic          rstN,
    input  logic          wr,
    input  logic          flush,
    input  exePkg::idExeT d,
    output exePkg::idExeT q,
    output logic [4:0]    shamt
);
    import exePkg::*;

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            q       <= '0;     // bubble
            q.aluOp <= opNop;  // zero opcode would decode as add
        end else if (wr) begin
            q <= d;
        end
    end

    assign shamt = q.instr[10:6];  // R-type sa field

endmodule

/* design/alu.sv */
`timescale 1ns/1ps
`include "exeStage_defines.svh"

module alu (
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    input  exePkg::aluOpE      op,
    output logic [`DATA_W-1:0] y,
    output logic               overflow
);
    import exePkg::*;

    logic [`DATA_W-1:0] sum;
    logic [`DATA_W-1:0] diff;
    logic [4:0]         amt;

    assign sum  = a + b;
    assign diff = a - b;
    assign amt  = a[4:0];  // shift amount, shamt or rs

    always_comb begin
        y        = '0;
        overflow = 1'b0;
        case (op)
            opAdd: begin
                y        = sum;
                overflow = (a[`DATA_W-1] == b[`DATA_W-1]) && (sum[`DATA_W-1] != a[`DATA_W-1]);
            end
            opAddu: y = sum;
            opSub: begin
                y        = diff;
                overflow = (a[`DATA_W-1] != b[`DATA_W-1]) && (diff[`DATA_W-1] != a[`DATA_W-1]);
            end
            opSubu: y = diff;
            opAnd:  y = a & b;
            opOr:   y = a | b;
            opXor:  y = a ^ b;
            opNor:  y = ~(a | b);
            opSlt:  y = `DATA_W'($signed(a) < $signed(b));
            opSltu: y = `DATA_W'(a < b);
            opSll:  y = b << amt;
            opSrl:  y = b >> amt;
            opSra:  y = $signed(b) >>> amt;
            opLui:  y = {b[15:0], 16'b0};
            default: y = '0;  // mdu ops and nop
        endcase
    end

    // checks on the decoded opcode coming out of the pipeline register
    always_comb begin
        if (!$isunknown(op)) begin
            assert (op <= opNop)
                else $error("alu: opcode %0d outside the defined set", op);
        end
    end

endmodule

/* design/branchSolve.sv */
`timescale 1ns/1ps
`include "exeStage_defines.svh"

module branchSolve (
    input  exePkg::branchTypeE branchType,
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    output logic               taken
);
    import exePkg::*;

    logic aNeg;
    logic aZero;

    assign aNeg  = a[`DATA_W-1];
    assign aZero = (a == '0);

    always_comb begin
        case (branchType)
            brBeq:   taken = (a == b);
            brBne:   taken = (a != b);
            brBgez:  taken = !aNeg;
            brBgtz:  taken = !aNeg && !aZero;
            brBlez:  taken = aNeg || aZero;
            brBltz:  taken = aNeg;
            brJr:    taken = 1'b1;  // register jump always redirects
            default: taken = 1'b0;
        endcase
    end

endmodule

/* design/multDiv.sv */
`timescale 1ns/1ps
`include "exeStage_defines.svh"

module multDiv (
    input  logic               clk,
    input  logic               rstN,
    input  logic               abort,
    input  exePkg::aluOpE      op,
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    output logic               stall,
    output logic               finish,
    output logic [`DATA_W-1:0] hi,
    output logic [`DATA_W-1:0] lo
);
    import exePkg::*;

    typedef enum logic [1:0] {idle, mulBusy, divBusy, done} stateE;

    function automatic logic [2*`DATA_W-1:0] divStep(input logic [`DATA_W-1:0] r,
                                                     input logic [`DATA_W-1:0] q,
                                                     input logic [`DATA_W-1:0] d);
        logic [`DATA_W:0] shifted;
        logic [`DATA_W:0] trial;
        shifted = {r, q[`DATA_W-1]};
        trial   = shifted - {1'b0, d};
        if (trial[`DATA_W])
            return {shifted[`DATA_W-1:0], q[`DATA_W-2:0], 1'b0};  // restore
        return {trial[`DATA_W-1:0], q[`DATA_W-2:0], 1'b1};
    endfunction

    stateE                state;
    logic [5:0]           count;
    logic                 isMul;
    logic                 isDiv;
    logic                 isSigned;
    logic                 start;
    logic [`DATA_W-1:0]   absA;
    logic [`DATA_W-1:0]   absB;
    logic [2*`DATA_W-1:0] product;
    logic [2*`DATA_W-1:0] mulStage;
    logic [2*`DATA_W-1:0] divNext;
    logic [`DATA_W-1:0]   rem;
    logic [`DATA_W-1:0]   quo;
    logic [`DATA_W-1:0]   divisor;
    logic                 negQuo;
    logic                 negRem;
    logic                 divMode;

    assign isMul    = op inside {opMult, opMultu};
    assign isDiv    = op inside {opDiv, opDivu};
    assign isSigned = op inside {opMult, opDiv};
    assign start    = (state == idle) && (isMul || isDiv);

    assign absA = (isSigned && a[`DATA_W-1]) ? -a : a;
    assign absB = (isSigned && b[`DATA_W-1]) ? -b : b;

    always_comb begin
        if (op == opMult)
            product = $signed({{`DATA_W{a[`DATA_W-1]}}, a}) * $signed({{`DATA_W{b[`DATA_W-1]}}, b});
        else
            product = {{`DATA_W{1'b0}}, a} * {{`DATA_W{1'b0}}, b};
    end

    // first divide step runs in the start cycle on the fresh operands
    assign divNext = (state == idle) ? divStep('0, absA, absB) : divStep(rem, quo, divisor);

    always_ff @(posedge clk) begin
        if (!rstN || abort) begin
            state <= idle;
            count <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        count <= 6'd1;
                        state <= isMul ? mulBusy : divBusy;
                    end
                end
                mulBusy: begin
                    count <= count + 6'd1;
                    if (count == 6'(`MULT_STEPS - 1)) state <= done;
                end
                divBusy: begin
                    count <= count + 6'd1;
                    if (count == 6'(`DIV_STEPS - 1)) state <= done;
                end
                default: state <= idle;  // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            negQuo   <= isSigned && (a[`DATA_W-1] ^ b[`DATA_W-1]);
            negRem   <= isSigned && a[`DATA_W-1];  // remainder follows dividend
            divMode  <= isDiv;
            divisor  <= absB;
            mulStage <= product;
        end
        if ((start && isDiv) || state == divBusy) {rem, quo} <= divNext;
        if (state == mulBusy) {rem, quo} <= mulStage;  // second product register
    end

    assign stall  = start || state == mulBusy || state == divBusy;
    assign finish = (state == done);
    assign hi     = (divMode && negRem) ? -rem : rem;
    assign lo     = (divMode && negQuo) ? -quo : quo;

    assert property (@(posedge clk) disable iff (!rstN) finish |=> !finish)
        else $error("multDiv: finish held longer than one cycle");

    // a stall ends only through finish or a flush
    assert property (@(posedge clk) disable iff (!rstN) (stall && !abort) |=> (stall || finish))
        else $error("multDiv: stall dropped without finish or abort");

endmodule

/* design/hiLo.sv */
`timescale 1ns/1ps
`include "exeStage_defines.svh"

module hiLo (
    input  logic               clk,
    input  logic               rstN,
    input  logic               finish,
    input  exePkg::regsWrT     wr,
    input  logic [`DATA_W-1:0] dataWr,
    input  logic [`DATA_W-1:0] mdHi,
    input  logic [`DATA_W-1:0] mdLo,
    output logic [`DATA_W-1:0] hi,
    output logic [`DATA_W-1:0] lo
);
    import exePkg::*;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hi <= '0;
            lo <= '0;
        end else if (finish) begin
            hi <= mdHi;  // mdu result takes both halves
            lo <= mdLo;
        end else begin
            if (wr.hiWr) hi <= dataWr;  // mthi
            if (wr.loWr) lo <= dataWr;  // mtlo
        end
    end

endmodule

/* design/exeStage.sv */
`timescale 1ns/1ps
`include "exeStage_defines.svh"

module exeStage (
    input  logic               clk,
    input  logic               rstN,
    input  logic               exeWr,
    input  logic               exeFlush,
    input  logic               exeDisWr,
    input  exePkg::idExeT      idExe,
    output exePkg::exeMemT     exeMem,
    output logic               idFlush,
    output logic               mduStall,
    output logic [`DATA_W-1:0] exeBusA,
    output logic [`DATA_W-1:0] exePc,
    output logic [`DATA_W-1:0] exeImm32
);
    import exePkg::*;

    idExeT              ex;
    logic [4:0]         shamt;
    logic [`DATA_W-1:0] aluA;
    logic [`DATA_W-1:0] aluB;
    logic [`DATA_W-1:0] aluOut;
    logic               aluOverflow;
    logic [`DATA_W-1:0] outB;
    logic               mdFinish;
    logic [`DATA_W-1:0] mdHi;
    logic [`DATA_W-1:0] mdLo;
    logic [`DATA_W-1:0] hi;
    logic [`DATA_W-1:0] lo;
    logic               finalFinish;
    regsWrT             finalWr;

    exeReg uExeReg (
        .clk   (clk),
        .rstN  (rstN),
        .wr    (exeWr),
        .flush (exeFlush),
        .d     (idExe),
        .q     (ex),
        .shamt (shamt)
    );

    assign aluA = ex.aluSrcA ? {{(`DATA_W - 5){1'b0}}, shamt} : ex.busA;
    assign aluB = ex.aluSrcB ? ex.imm32 : ex.busB;

    alu uAlu (
        .a        (aluA),
        .b        (aluB),
        .op       (ex.aluOp),
        .y        (aluOut),
        .overflow (aluOverflow)
    );

    branchSolve uBranchSolve (
        .branchType (ex.branchType),
        .a          (ex.busA),
        .b          (ex.busB),
        .taken      (idFlush)
    );

    multDiv uMultDiv (
        .clk    (clk),
        .rstN   (rstN),
        .abort  (exeFlush),  // flush drops any divide in flight
        .op     (ex.aluOp),
        .a      (ex.busA),
        .b      (ex.busB),
        .stall  (mduStall),
        .finish (mdFinish),
        .hi     (mdHi),
        .lo     (mdLo)
    );

    // older faulting instruction in mem kills all writes from here
    assign finalWr     = exeDisWr ? '0 : ex.regsWr;
    assign finalFinish = exeDisWr ? 1'b0 : mdFinish;

    hiLo uHiLo (
        .clk    (clk),
        .rstN   (rstN),
        .finish (finalFinish),
        .wr     (finalWr),
        .dataWr (ex.busA),
        .mdHi   (mdHi),
        .mdLo   (mdLo),
        .hi     (hi),
        .lo     (lo)
    );

    always_comb begin
        case (ex.readSel)
            readHi:  outB = hi;
            readLo:  outB = lo;
            default: outB = ex.busB;
        endcase
    end

    always_comb begin
        exeMem        = '0;
        exeMem.pc     = ex.pc;
        exeMem.aluOut = aluOut;
        exeMem.outB   = outB;
        case (ex.wbSel)
            wbLink:   exeMem.result = ex.pc + `DATA_W'(`LINK_OFFSET);
            wbAluOut: exeMem.result = aluOut;
            default:  exeMem.result = outB;
        endcase
        case (ex.dstSel)
            dstRt:   exeMem.dst = ex.rt;
            dstRa:   exeMem.dst = `REG_ADDR_W'(31);
            default: exeMem.dst = ex.rd;
        endcase
        exeMem.regsWr          = finalWr;
        exeMem.wbSel           = ex.wbSel;
        exeMem.except          = ex.except;
        exeMem.except.overflow = ex.except.overflow | aluOverflow;
    end

    assign exeBusA  = ex.busA;  // jr target
    assign exePc    = ex.pc;
    assign exeImm32 = ex.imm32;

endmodule

/* verification/exeStageTb.sv */
`timescale 1ns/1ps
`include "exeStage_defines.svh"

module exeStageTb;
    import exePkg::*;

    logic               clk;
    logic               rstN;
    logic               exeWr;
    logic               exeFlush;
    logic               exeDisWr;
    idExeT              idExe;
    exeMemT             exeMem;
    logic               idFlush;
    logic               mduStall;
    logic [`DATA_W-1:0] exeBusA;
    logic [`DATA_W-1:0] exePc;
    logic [`DATA_W-1:0] exeImm32;
    logic [31:0]        lfsr;
    logic [31:0]        refHi;  // HI/LO as the ISA says they should be
    logic [31:0]        refLo;
    int                 checks;

    exeStage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic idExeT nopInstr();
        idExeT i;
        i            = '0;
        i.aluOp      = opNop;
        i.wbSel      = wbAluOut;
        i.dstSel     = dstRd;
        i.readSel    = readBusB;
        i.branchType = brNone;
        return i;
    endfunction

    function automatic logic [31:0] aluResult(input aluOpE op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            opAdd, opAddu: return a + b;
            opSub, opSubu: return a - b;
            opAnd:   return a & b;
            opOr:    return a | b;
            opXor:   return a ^ b;
            opNor:   return ~(a | b);
            opSlt:   return {31'b0, $signed(a) < $signed(b)};
            opSltu:  return {31'b0, a < b};
            opSll:   return b << a[4:0];  // amount in a, value in b
            opSrl:   return b >> a[4:0];
            opSra:   return 32'($signed(b) >>> a[4:0]);
            opLui:   return b << 16;
            default: return 32'b0;
        endcase
    endfunction

    function automatic logic signedOverflow(input aluOpE op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic signed [32:0] wide;
        if (op == opAdd)
            wide = $signed({a[31], a}) + $signed({b[31], b});
        else if (op == opSub)
            wide = $signed({a[31], a}) - $signed({b[31], b});
        else
            return 1'b0;
        return wide[32] != wide[31];  // 33-bit result does not fit in 32
    endfunction

    function automatic logic branchTaken(input branchTypeE t, input logic [31:0] a,
                                         input logic [31:0] b);
        case (t)
            brBeq:   return a == b;
            brBne:   return a != b;
            brBgez:  return $signed(a) >= 0;
            brBgtz:  return $signed(a) > 0;
            brBlez:  return $signed(a) <= 0;
            brBltz:  return $signed(a) < 0;
            brJr:    return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // {hi, lo} for mult/multu and {remainder, quotient} for div/divu
    function automatic logic [63:0] mduResult(input aluOpE op, input logic [31:0] a,
                                              input logic [31:0] b);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = {32'b0, a};
        ub = {32'b0, b};
        case (op)
            opMult:  return sa * sb;
            opMultu: return ua * ub;
            opDiv:   return {32'($signed(a) % $signed(b)), 32'($signed(a) / $signed(b))};
            default: return {a % b, a / b};
        endcase
    endfunction

    function automatic logic [4:0] destReg(input idExeT i);
        case (i.dstSel)
            dstRt:   return i.rt;
            dstRa:   return 5'd31;
            default: return i.rd;
        endcase
    endfunction

    function automatic logic [31:0] linkAddr(input logic [31:0] pc);
        return pc + 32'd8;
    endfunction

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        checks++;
        if (actual !== expected) begin
            $display("ERR %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
            $display("tests failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // called 5 ns after an edge, returns 5 ns after the edge that loads ins
    task automatic loadInstr(input idExeT ins);
        idExe = ins;
        exeWr = 1'b1;
        @(posedge clk);
        #5;
        exeWr = 1'b0;
    endtask

    // exeWr stays low while the unit is busy
    task automatic waitMdu(input int expected);
        int cycles;
        cycles = 0;
        while (mduStall) begin
            @(posedge clk);
            #5;
            cycles++;
            if (cycles >= 200) begin
                $display("the multiply/divide never finished, mduStall high for 200 cycles");
                $display("tests failed");
                $fatal(1, "timeout waiting for mduStall to drop");
            end
        end
        compare(32'(cycles), 32'(expected), "multiply/divide latency");
    endtask

    task automatic readHiLo();
        idExeT ins;
        ins              = nopInstr();
        ins.wbSel        = wbOutB;
        ins.regsWr.gprWr = 1'b1;
        ins.readSel      = readHi;  // mfhi
        loadInstr(ins);
        compare(exeMem.result, refHi, "HI read");
        ins.readSel = readLo;  // mflo
        loadInstr(ins);
        compare(exeMem.result, refLo, "LO read");
    endtask

    initial begin
        idExeT       ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expAlu;
        logic [63:0] md;
        lfsr     = 32'd70370;
        checks   = 0;
        refHi    = '0;
        refLo    = '0;
        rstN     = 1'b0;
        exeWr    = 1'b0;
        exeFlush = 1'b0;
        exeDisWr = 1'b0;
        idExe    = nopInstr();
        repeat (8) @(posedge clk);
        #5;
        rstN = 1'b1;
        compare(32'(mduStall), 32'd0, "mduStall after reset");
        compare(32'(idFlush), 32'd0, "idFlush after reset");
        compare({29'b0, exeMem.regsWr}, 32'd0, "write flags after reset");
        readHiLo();

        // odd passes take shifts from shamt and push add/sub into overflow
        for (int rep = 0; rep < 6; rep++) begin
            for (int k = int'(opAdd); k <= int'(opLui); k++) begin
                ins              = nopInstr();
                ins.aluOp        = aluOpE'(5'(k));
                ins.busA         = randBits(32);
                ins.busB         = randBits(32);
                ins.imm32        = randBits(32);
                ins.instr        = randBits(32);
                ins.rt           = 5'(randBits(5));
                ins.rd           = 5'(randBits(5));
                ins.dstSel       = dstSelE'(2'(randBits(2) % 3));
                ins.aluSrcA      = (rep % 2 == 1) && (ins.aluOp inside {opSll, opSrl, opSra});
                ins.aluSrcB      = 1'(randBits(1));
                ins.except       = exceptT'(4'(randBits(3)));  // decode-side flags only
                ins.regsWr.gprWr = 1'b1;
                if (rep % 2 == 1 && ins.aluOp inside {opAdd, opSub}) begin
                    ins.aluSrcB = 1'b0;
                    ins.busA    = {2'b01, 30'(randBits(30))};
                    if (ins.aluOp == opSub)
                        ins.busB = {2'b10, 30'(randBits(30))};
                    else
                        ins.busB = {2'b01, 30'(randBits(30))};
                end
                a      = ins.aluSrcA ? {27'b0, ins.instr[10:6]} : ins.busA;
                b      = ins.aluSrcB ? ins.imm32 : ins.busB;
                expAlu = aluResult(ins.aluOp, a, b);
                loadInstr(ins);
                compare(exeMem.result, expAlu, "ALU result");
                compare(exeMem.aluOut, expAlu, "ALU output field");
                compare(exeMem.outB, ins.busB, "store data");
                compare(32'(exeMem.dst), 32'(destReg(ins)), "destination");
                compare(32'(exeMem.except.overflow), 32'(signedOverflow(ins.aluOp, a, b)),
                        "overflow flag");
                compare(32'(exeMem.except[2:0]), 32'(ins.except[2:0]),
                        "carried exception flags");
                compare({29'b0, exeMem.regsWr}, 32'b100, "write flags");
                if (rep % 2 == 1 && ins.aluOp inside {opAdd, opSub})
                    compare(32'(exeMem.except.overflow), 32'd1, "forced overflow");
            end
        end

        for (int t = int'(brNone); t <= int'(brJr); t++) begin
            for (int c = 0; c < 4; c++) begin
                ins            = nopInstr();
                ins.branchType = branchTypeE'(3'(t));
                ins.pc         = {30'(randBits(30)), 2'b00};
                ins.imm32      = randBits(32);
                ins.busB       = randBits(32);
                case (c)
                    0: ins.busA = ins.busB;  // equal
                    1: ins.busA = ~ins.busB;
                    2: ins.busA = {1'b1, 31'(randBits(31))};  // negative
                    default: ins.busA = '0;
                endcase
                if (c % 2 == 1) begin  // linking form, bltzal or jalr style
                    ins.wbSel        = wbLink;
                    ins.dstSel       = dstRa;
                    ins.regsWr.gprWr = 1'b1;
                end
                loadInstr(ins);
                compare(32'(idFlush), 32'(branchTaken(ins.branchType, ins.busA, ins.busB)),
                        "branch taken");
                compare(exeBusA, ins.busA, "jump register target");
                compare(exePc, ins.pc, "pc to fetch");
                compare(exeImm32, ins.imm32, "branch offset to fetch");
                compare(exeMem.pc, ins.pc, "pc carried forward");
                compare(32'(exeMem.wbSel), 32'(ins.wbSel), "write back select");
                if (c % 2 == 1) begin
                    compare(exeMem.result, linkAddr(ins.pc), "link value");
                    compare(32'(exeMem.dst), 32'(destReg(ins)), "link destination");
                end
            end
        end

        for (int rep = 0; rep < 8; rep++) begin
            ins       = nopInstr();
            ins.aluOp = aluOpE'(5'(int'(opMult) + rep % 4));
            ins.busA  = randBits(32);
            ins.busB  = randBits(32);
            ins.busB  = ins.busB >> randBits(4);  // small divisors too
            if (ins.busB == '0 || ins.busB == '1)
                ins.busB = 32'd7;
            md = mduResult(ins.aluOp, ins.busA, ins.busB);
            loadInstr(ins);
            compare(32'(mduStall), 32'd1, "mduStall at start");
            waitMdu((ins.aluOp inside {opDiv, opDivu}) ? `DIV_STEPS : `MULT_STEPS);
            refHi = md[63:32];
            refLo = md[31:0];
            readHiLo();
        end

        for (int rep = 0; rep < 4; rep++) begin
            ins      = nopInstr();
            ins.busA = randBits(32);
            if (rep % 2 == 0) begin
                ins.aluOp       = opMthi;
                ins.regsWr.hiWr = 1'b1;
                refHi           = ins.busA;
            end else begin
                ins.aluOp       = opMtlo;
                ins.regsWr.loWr = 1'b1;
                refLo           = ins.busA;
            end
            loadInstr(ins);
            readHiLo();
        end

        // flush in the middle of a divide
        ins       = nopInstr();
        ins.aluOp = opDiv;
        ins.busA  = randBits(32);
        ins.busB  = 32'd3;
        loadInstr(ins);
        repeat (5) begin
            @(posedge clk);
            #5;
        end
        compare(32'(mduStall), 32'd1, "divide busy before flush");
        exeFlush = 1'b1;
        @(posedge clk);
        #5;
        exeFlush = 1'b0;
        compare(32'(mduStall), 32'd0, "mduStall after flush");
        repeat (`DIV_STEPS) begin  // a late finish would land in here
            @(posedge clk);
            #5;
        end
        readHiLo();

        exeDisWr  = 1'b1;
        ins       = nopInstr();
        ins.aluOp = opMultu;
        ins.busA  = randBits(32);
        ins.busB  = randBits(32);
        loadInstr(ins);
        waitMdu(`MULT_STEPS);
        ins              = nopInstr();
        ins.aluOp        = opMthi;
        ins.regsWr.hiWr  = 1'b1;
        ins.regsWr.gprWr = 1'b1;
        ins.busA         = randBits(32);
        loadInstr(ins);  // finish edge goes by masked
        compare({29'b0, exeMem.regsWr}, 32'd0, "write flags under exeDisWr");
        loadInstr(nopInstr());
        exeDisWr = 1'b0;
        readHiLo();

        if (checks > 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "no checks were run");
        end
    end

endmodule

/* build.f */
+incdir+design
design/exePkg.sv
design/exeReg.sv
design/alu.sv
design/branchSolve.sv
design/multDiv.sv
design/hiLo.sv
design/exeStage.sv
verification/exeStageTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = exeStageTb
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
